/* src/cache_pkg.sv */
package cache_pkg;

    localparam int WORD_W         = 16;
    localparam int ADDR_W         = 16;
    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 3;
    localparam int WORDS_PER_LINE = 4;
    localparam int MEM_LATENCY    = 2;
    localparam int NUM_SETS       = 256;
    // Backing store is word addressed
    localparam int MEM_WORDS      = 2 ** (ADDR_W - 1);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_COMPARE_READ,
        ST_COMPARE_WRITE,
        ST_EVICT_0,
        ST_EVICT_1,
        ST_EVICT_2,
        ST_EVICT_3,
        ST_ALLOC_0,
        ST_ALLOC_1,
        ST_ALLOC_2,
        ST_ALLOC_3,
        ST_FILL_2,
        ST_FILL_3,
        ST_DONE_WAIT
    } ctrl_state_e;

    typedef struct packed {
        logic              ld;
        logic              st;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
        logic              done;
        logic              stall;
        logic              hit;
    } cpu_resp_t;

    typedef struct packed {
        logic                en0;
        logic                en1;
        logic                comp;
        logic                write;
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [WORD_W-1:0]   wdata;
        logic                dirty;
    } way_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] data;
    } way_lookup_t;

    typedef struct packed {
        logic              hit;
        logic              dirty;
        logic              way;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] data;
    } victim_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

endpackage

/* src/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   enable,
    input  cache_pkg::way_cmd_t    cmd,
    output cache_pkg::way_lookup_t lookup
);
    import cache_pkg::*;

    logic [TAG_W-1:0]    tag_arr   [NUM_SETS];
    logic                dirty_arr [NUM_SETS];
    logic [WORD_W-1:0]   data_arr  [NUM_SETS][WORDS_PER_LINE];
    logic [NUM_SETS-1:0] valid_arr;

    logic [$clog2(WORDS_PER_LINE)-1:0] word;
    logic                              wr_hit;
    logic                              wr_fill;

    // Byte offset to word within the line
    assign word = cmd.offset[OFFSET_W-1:1];

    always_comb begin
        lookup.valid = valid_arr[cmd.index];
        lookup.tag   = tag_arr[cmd.index];
        // Dirty only counts for a valid line
        lookup.dirty = valid_arr[cmd.index] & dirty_arr[cmd.index];
        lookup.data  = data_arr[cmd.index][word];
        lookup.hit   = enable & cmd.comp & valid_arr[cmd.index] &
                       (tag_arr[cmd.index] == cmd.tag);
    end

    assign wr_hit  = cmd.write & cmd.comp & lookup.hit;
    assign wr_fill = enable & cmd.write & ~cmd.comp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_arr <= '0;
        end else if (wr_fill) begin
            valid_arr[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit || wr_fill) begin
            data_arr[cmd.index][word] <= cmd.wdata;
        end
        if (wr_hit) begin
            dirty_arr[cmd.index] <= 1'b1;
        end else if (wr_fill) begin
            dirty_arr[cmd.index] <= cmd.dirty;
        end
        if (wr_fill) begin
            tag_arr[cmd.index] <= cmd.tag;
        end
    end

endmodule

/* src/victim_select.sv */
`timescale 1ns/1ps

module victim_select (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flip,
    input  cache_pkg::way_lookup_t way0,
    input  cache_pkg::way_lookup_t way1,
    output cache_pkg::victim_t     victim
);

    logic flip_q;
    logic sel;

    // Pseudo-random pick once both ways are full
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flip_q <= 1'b0;
        end else if (flip) begin
            flip_q <= ~flip_q;
        end
    end

    // Empty ways are filled first
    always_comb begin
        if (!way0.valid) begin
            sel = 1'b0;
        end else if (!way1.valid) begin
            sel = 1'b1;
        end else begin
            sel = flip_q;
        end
    end

    always_comb begin
        victim.hit   = way0.hit | way1.hit;
        victim.way   = sel;
        victim.dirty = sel ? way1.dirty : way0.dirty;
        victim.tag   = sel ? way1.tag : way0.tag;
        if (way0.hit) begin
            victim.data = way0.data;
        end else if (way1.hit) begin
            victim.data = way1.data;
        end else begin
            victim.data = sel ? way1.data : way0.data;
        end
    end

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cache_pkg::cpu_req_t          req,
    output cache_pkg::cpu_resp_t         resp,
    input  cache_pkg::victim_t           victim,
    output cache_pkg::way_cmd_t          way_cmd,
    output logic                         flip,
    output cache_pkg::mem_req_t          mem_req,
    input  logic [cache_pkg::WORD_W-1:0] mem_rdata
);
    import cache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;

    cpu_req_t          req_q;
    logic              vic_way_q;
    logic [TAG_W-1:0]  vic_tag_q;
    logic [WORD_W-1:0] rdata_q;

    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic [1:0]         req_word;
    logic               compare;
    logic               evict;
    logic               alloc;
    logic               fill;
    logic [1:0]         step;
    logic [1:0]         fill_word;
    logic [WORD_W-1:0]  fill_data;
    logic               done;

    assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_q.addr[OFFSET_W-1:1];

    assign compare = (state == ST_COMPARE_READ) || (state == ST_COMPARE_WRITE);
    assign evict   = state inside {ST_EVICT_0, ST_EVICT_1, ST_EVICT_2, ST_EVICT_3};
    assign alloc   = state inside {ST_ALLOC_0, ST_ALLOC_1, ST_ALLOC_2, ST_ALLOC_3};
    assign fill    = state inside {ST_ALLOC_2, ST_ALLOC_3, ST_FILL_2, ST_FILL_3};

    // Memory word for evict/alloc; fill lags it by two words
    always_comb begin
        case (state)
            ST_EVICT_1, ST_ALLOC_1, ST_FILL_3: step = 2'd1;
            ST_EVICT_2, ST_ALLOC_2:            step = 2'd2;
            ST_EVICT_3, ST_ALLOC_3:            step = 2'd3;
            default:                           step = 2'd0;
        endcase
    end

    assign fill_word = step + 2'd2;

    // Store miss merges its word into the fill
    assign fill_data = (req_q.st && fill_word == req_word) ? req_q.wdata : mem_rdata;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req.ld) begin
                    next_state = ST_COMPARE_READ;
                end else if (req.st) begin
                    next_state = ST_COMPARE_WRITE;
                end
            end
            ST_COMPARE_READ, ST_COMPARE_WRITE: begin
                if (victim.hit) begin
                    next_state = ST_IDLE;
                end else if (victim.dirty) begin
                    next_state = ST_EVICT_0;
                end else begin
                    next_state = ST_ALLOC_0;
                end
            end
            ST_EVICT_0: next_state = ST_EVICT_1;
            ST_EVICT_1: next_state = ST_EVICT_2;
            ST_EVICT_2: next_state = ST_EVICT_3;
            ST_EVICT_3: next_state = ST_ALLOC_0;
            ST_ALLOC_0: next_state = ST_ALLOC_1;
            ST_ALLOC_1: next_state = ST_ALLOC_2;
            ST_ALLOC_2: next_state = ST_ALLOC_3;
            ST_ALLOC_3: next_state = ST_FILL_2;
            ST_FILL_2:  next_state = ST_FILL_3;
            // FILL_3 and the reserved state
            default:    next_state = ST_IDLE;
        endcase
    end

    always_comb begin
        way_cmd        = '0;
        way_cmd.tag    = req_tag;
        way_cmd.index  = req_index;
        way_cmd.offset = req_q.addr[OFFSET_W-1:0];
        way_cmd.wdata  = req_q.wdata;
        way_cmd.dirty  = req_q.st;
        if (compare) begin
            way_cmd.en0   = 1'b1;
            way_cmd.en1   = 1'b1;
            way_cmd.comp  = 1'b1;
            way_cmd.write = (state == ST_COMPARE_WRITE);
        end else if (evict) begin
            // Victim way hits on its own tag and drives the data
            way_cmd.en0    = ~vic_way_q;
            way_cmd.en1    = vic_way_q;
            way_cmd.comp   = 1'b1;
            way_cmd.tag    = vic_tag_q;
            way_cmd.offset = {step, 1'b0};
        end else if (fill) begin
            way_cmd.en0    = ~vic_way_q;
            way_cmd.en1    = vic_way_q;
            way_cmd.write  = 1'b1;
            way_cmd.offset = {fill_word, 1'b0};
            way_cmd.wdata  = fill_data;
        end
    end

    assign mem_req.rd    = alloc;
    assign mem_req.wr    = evict;
    assign mem_req.addr  = evict ? {vic_tag_q, req_index, step, 1'b0}
                                 : {req_tag, req_index, step, 1'b0};
    assign mem_req.wdata = victim.data;

    assign flip = compare;

    assign done       = (compare && victim.hit) || (fill && fill_word == req_word);
    assign resp.done  = done;
    assign resp.stall = (state != ST_IDLE);
    assign resp.hit   = compare & victim.hit;
    assign resp.rdata = !done ? rdata_q : (compare ? victim.data : fill_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && (req.ld || req.st)) begin
            req_q <= req;
        end
        if (compare) begin
            vic_way_q <= victim.way;
            vic_tag_q <= victim.tag;
        end
        if (done) begin
            rdata_q <= resp.rdata;
        end
    end

endmodule

/* src/main_mem.sv */
`timescale 1ns/1ps

module main_mem (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cache_pkg::mem_req_t          req,
    output logic [cache_pkg::WORD_W-1:0] rdata
);
    import cache_pkg::*;

    logic [WORD_W-1:0]      mem     [MEM_WORDS];
    logic [WORD_W-1:0]      rd_pipe [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] rd_vld;
    logic [ADDR_W-2:0]      waddr;

    assign waddr = req.addr[ADDR_W-1:1];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.wr) begin
            mem[waddr] <= req.wdata;
        end
    end

    // Read data moves one stage per clock
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[waddr];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[MEM_LATENCY-2:0], req.rd};
        end
    end

    assign rdata = rd_vld[MEM_LATENCY-1] ? rd_pipe[MEM_LATENCY-1] : '0;

endmodule

/* src/mem_system.sv */
`timescale 1ns/1ps

module mem_system (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cache_pkg::cpu_req_t  req,
    output cache_pkg::cpu_resp_t resp
);
    import cache_pkg::*;

    way_cmd_t          way_cmd;
    way_lookup_t       lookup0;
    way_lookup_t       lookup1;
    victim_t           victim;
    logic              flip;
    mem_req_t          mem_req;
    logic [WORD_W-1:0] mem_rdata;

    cache_ctrl ctrl_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .resp      (resp),
        .victim    (victim),
        .way_cmd   (way_cmd),
        .flip      (flip),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    cache_way way0_i (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (way_cmd.en0),
        .cmd    (way_cmd),
        .lookup (lookup0)
    );

    cache_way way1_i (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (way_cmd.en1),
        .cmd    (way_cmd),
        .lookup (lookup1)
    );

    victim_select victim_i (
        .clk    (clk),
        .arst_n (arst_n),
        .flip   (flip),
        .way0   (lookup0),
        .way1   (lookup1),
        .victim (victim)
    );

    main_mem mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rdata  (mem_rdata)
    );

endmodule

/* bench/tb_mem_system.sv */
`timescale 1ns/1ps

module tb_mem_system;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_OPS     = 200;

    typedef struct packed {
        logic              ld;
        logic              hit;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } expect_t;

    logic      clk;
    logic      arst_n;
    cpu_req_t  req;
    cpu_resp_t resp;

    // Reference state holds the true memory contents and the tags of each way
    logic [WORD_W-1:0] ref_mem   [MEM_WORDS];
    logic              ref_valid [2][NUM_SETS];
    logic [TAG_W-1:0]  ref_tag   [2][NUM_SETS];
    logic              ref_flip;

    expect_t exp_q[$];
    int      done_count;
    int      check_count;
    int      err_count;
    int      test_count;
    integer  seed;

    mem_system dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .resp   (resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] idx,
                                                    input logic [1:0] word);
        return {tag, idx, word, 1'b0};
    endfunction

    // Expected response of one access; advances the model
    function automatic expect_t model_access(input logic st, input logic [ADDR_W-1:0] addr,
                                             input logic [WORD_W-1:0] wdata);
        expect_t            e;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] idx;
        logic               way;
        tag    = addr[ADDR_W-1 -: TAG_W];
        idx    = addr[OFFSET_W +: INDEX_W];
        e.ld   = ~st;
        e.addr = addr;
        e.hit  = (ref_valid[0][idx] && ref_tag[0][idx] == tag) ||
                 (ref_valid[1][idx] && ref_tag[1][idx] == tag);
        if (!e.hit) begin
            // Empty way first or else the flip bit
            if (!ref_valid[0][idx]) begin
                way = 1'b0;
            end else if (!ref_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = ref_flip;
            end
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx]   = tag;
        end
        ref_flip = ~ref_flip;
        if (st) begin
            ref_mem[addr[ADDR_W-1:1]] = wdata;
        end
        e.data = ref_mem[addr[ADDR_W-1:1]];
        return e;
    endfunction

    always @(negedge clk) begin : compare_resp
        expect_t e;
        if (arst_n && resp.done) begin
            done_count++;
            if (exp_q.size() == 0) begin
                $display("done pulse at %0t with no request outstanding", $time);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                check_count++;
                assert (resp.hit == e.hit) else begin
                    $display("[FAIL] resp.hit addr %h: got %h expected %h",
                             e.addr, resp.hit, e.hit);
                    err_count++;
                end
                if (e.ld) begin
                    check_count++;
                    assert (resp.rdata == e.data) else begin
                        $display("[FAIL] resp.rdata addr %h: got %h expected %h",
                                 e.addr, resp.rdata, e.data);
                        err_count++;
                    end
                end
            end
        end
    end

    // One load or store that waits for done and then for the end of stall
    task automatic access(input logic st, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata);
        int start_done;
        int cycles;
        exp_q.push_back(model_access(st, addr, wdata));
        start_done = done_count;
        @(posedge clk);
        #2;
        req.ld    = ~st;
        req.st    = st;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        #2;
        req.ld = 1'b0;
        req.st = 1'b0;
        cycles = 0;
        while (done_count == start_done && resp.stall && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (done_count == start_done) begin
            if (!resp.stall) begin
                $display("stall ended without a done pulse for address %h", addr);
            end else begin
                $display("no done pulse within %0d cycles for address %h", cycles, addr);
            end
            err_count++;
            exp_q.delete();
        end
        cycles = 0;
        while (resp.stall && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (resp.stall) begin
            $display("stall still high %0d cycles after done for address %h", cycles, addr);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
        end
    endtask

    initial begin
        int                 errs;
        logic [31:0]        r;
        logic [INDEX_W-1:0] idx;
        seed        = 32'h84c7;
        req         = '0;
        arst_n      = 1'b0;
        done_count  = 0;
        check_count = 0;
        err_count   = 0;
        test_count  = 0;
        ref_flip    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < NUM_SETS; i++) begin
            ref_valid[0][i] = 1'b0;
            ref_valid[1][i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        errs = err_count;
        access(1'b0, 16'h1a34, '0);
        access(1'b0, 16'h1a34, '0);
        report_test("cold load then repeat hit", errs);

        errs = err_count;
        access(1'b1, make_addr(5'd3, 8'h20, 2'd2), 16'hbeef);
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(5'd3, 8'h20, 2'(w)), '0);
        end
        report_test("store then loads of the line", errs);

        errs = err_count;
        for (int k = 0; k < 4; k++) begin
            idx = 8'h40 + 8'(k);
            for (int w = 0; w < 4; w++) begin
                access(1'b1, make_addr(5'd1, idx, 2'(w)), 16'(32'h1100 + k * 16 + w));
            end
            // Three other tags push the dirty line out to memory
            for (int t = 2; t < 5; t++) begin
                access(1'b0, make_addr(5'(t), idx, 2'd0), '0);
            end
            access(1'b1, make_addr(5'd1, idx, 2'(k)), 16'(32'hc000 + k));
            for (int w = 0; w < 4; w++) begin
                access(1'b0, make_addr(5'd1, idx, 2'(w)), '0);
            end
        end
        report_test("store miss merge at each offset", errs);

        errs = err_count;
        for (int t = 8; t < 11; t++) begin
            access(1'b1, make_addr(5'(t), 8'h80, 2'd0), 16'(32'h5a00 + t));
            access(1'b1, make_addr(5'(t), 8'h80, 2'd3), 16'(32'ha500 + t));
        end
        for (int t = 8; t < 11; t++) begin
            access(1'b0, make_addr(5'(t), 8'h80, 2'd0), '0);
            access(1'b0, make_addr(5'(t), 8'h80, 2'd3), '0);
        end
        report_test("dirty evictions in one set", errs);

        errs = err_count;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            access(r[6], make_addr(5'd20 + 5'(r[1:0]), 8'hc0 + 8'(r[3:2]), r[5:4]),
                   r[31:16]);
        end
        report_test("random loads and stores", errs);

        repeat (2) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
src/cache_pkg.sv
src/cache_way.sv
src/victim_select.sv
src/cache_ctrl.sv
src/main_mem.sv
src/mem_system.sv
bench/tb_mem_system.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_system -f flist.f \
    && ./obj_dir/Vtb_mem_system > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
